/* filelist.f */
+incdir+hw
hw/enc_pkg.sv
hw/word_sram.sv
hw/word_scanner.sv
hw/vocab_matcher.sv
hw/encode_ctrl.sv
hw/token_encoder.sv
sim/tb_clock.sv
sim/token_encoder_tb.sv

/* hw/enc_macros.svh */
`ifndef ENC_MACROS_SVH
`define ENC_MACROS_SVH

// 32 bytes per memory
`define ENC_ADDR_W 5
`define ENC_DATA_W 8

// Longest word the scanner buffers
`define ENC_MAX_WORD 4

// Top bit of an output byte marks a vocabulary code
`define ENC_CODE_BIT 7

`endif

/* hw/enc_pkg.sv */
`include "enc_macros.svh"

package enc_pkg;

    typedef enum logic {
        SEL_INPUT,
        SEL_VOCAB
    } mem_sel_e;

    typedef struct packed {
        logic [2:0]                                len;
        logic [`ENC_MAX_WORD-1:0][`ENC_DATA_W-1:0] chars; // chars[0] is the first character
    } word_t;

    typedef struct packed {
        word_t                  word;
        logic                   empty;     // Zero length means the text has ended
        logic [`ENC_ADDR_W-1:0] next_addr; // Just past the terminating zero
    } scan_t;

    typedef struct packed {
        logic                     found;
        logic [`ENC_CODE_BIT-1:0] index;
    } match_t;

    typedef struct packed {
        logic                     is_code;
        logic [`ENC_CODE_BIT-1:0] index;
    } code_t;

    typedef union packed {
        logic [`ENC_DATA_W-1:0] raw;
        code_t                  code;
    } out_byte_u;

endpackage

/* hw/encode_ctrl.sv */
`timescale 1ns/1ns
`include "enc_macros.svh"

module encode_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    output logic                   done,
    output logic                   word_go,
    output logic [`ENC_ADDR_W-1:0] word_addr,
    input  logic                   scan_done,
    input  enc_pkg::scan_t         scan,
    input  logic                   match_done,
    input  enc_pkg::match_t        match,
    output logic                   out_we,
    output logic [`ENC_ADDR_W-1:0] out_waddr,
    output enc_pkg::out_byte_u     out_wdata
);

    import enc_pkg::*;

    typedef enum logic [2:0] {
        C_IDLE,
        C_WAIT,
        C_LIT,
        C_ZERO,
        C_FIN
    } state_e;

    state_e               state;
    logic                 scan_seen;
    logic                 match_seen;
    logic                 both;
    logic [2:0]           cnt;
    logic [`ENC_ADDR_W:0] optr; // One spare bit to catch overflow

    // Done pulses may arrive in either order or together
    assign both = (scan_seen | scan_done) & (match_seen | match_done);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= C_IDLE;
            done       <= 1'b0;
            word_go    <= 1'b0;
            word_addr  <= '0;
            scan_seen  <= 1'b0;
            match_seen <= 1'b0;
            out_we     <= 1'b0;
            optr       <= '0;
            cnt        <= '0;
        end else begin
            word_go <= 1'b0;
            out_we  <= 1'b0;
            case (state)
                C_IDLE: begin
                    if (start) begin
                        done       <= 1'b0;
                        optr       <= '0;
                        word_addr  <= '0;
                        word_go    <= 1'b1;
                        scan_seen  <= 1'b0;
                        match_seen <= 1'b0;
                        state      <= C_WAIT;
                    end
                end
                C_WAIT: begin
                    scan_seen  <= scan_seen | scan_done;
                    match_seen <= match_seen | match_done;
                    if (both) begin
                        scan_seen  <= 1'b0;
                        match_seen <= 1'b0;
                        if (scan.empty) begin
                            out_we <= 1'b1; // Final zero of the stream
                            optr   <= optr + 1'b1;
                            state  <= C_FIN;
                        end else if (match.found) begin
                            out_we <= 1'b1;
                            optr   <= optr + 1'b1;
                            state  <= C_ZERO;
                        end else begin
                            cnt   <= '0;
                            state <= C_LIT;
                        end
                    end
                end
                C_LIT: begin
                    out_we <= 1'b1;
                    optr   <= optr + 1'b1;
                    cnt    <= cnt + 3'd1;
                    if (cnt + 3'd1 == scan.word.len) begin
                        state <= C_ZERO;
                    end
                end
                C_ZERO: begin
                    out_we    <= 1'b1;
                    optr      <= optr + 1'b1;
                    word_addr <= scan.next_addr;
                    word_go   <= 1'b1;
                    state     <= C_WAIT;
                end
                C_FIN: begin
                    done  <= 1'b1;
                    state <= C_IDLE;
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        out_waddr <= optr[`ENC_ADDR_W-1:0];
        case (state)
            C_WAIT: begin
                if (both && !scan.empty && match.found) begin
                    out_wdata.code <= code_t'{is_code: 1'b1, index: match.index};
                end else begin
                    out_wdata.raw <= '0;
                end
            end
            C_LIT:   out_wdata.raw <= scan.word.chars[cnt];
            default: out_wdata.raw <= '0;
        endcase
    end

    // optr is one past the byte being written
    a_out_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        out_we |-> optr <= (1 << `ENC_ADDR_W))
        else $error("encode_ctrl: output stream overran the output memory");

endmodule

/* hw/token_encoder.sv */
`timescale 1ns/1ns
`include "enc_macros.svh"

module token_encoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load_en,
    input  enc_pkg::mem_sel_e      load_sel,
    input  logic [`ENC_ADDR_W-1:0] load_addr,
    input  logic [`ENC_DATA_W-1:0] load_data,
    input  logic                   start,
    output logic                   done,
    input  logic [`ENC_ADDR_W-1:0] out_addr,
    output enc_pkg::out_byte_u     out_data
);

    import enc_pkg::*;

    logic                   in_we;
    logic                   voc_we;
    logic                   word_go;
    logic [`ENC_ADDR_W-1:0] word_addr;
    logic [`ENC_ADDR_W-1:0] scan_addr;
    logic [`ENC_DATA_W-1:0] scan_data;
    logic [`ENC_ADDR_W-1:0] match_in_addr;
    logic [`ENC_DATA_W-1:0] match_in_data;
    logic [`ENC_ADDR_W-1:0] voc_addr;
    logic [`ENC_DATA_W-1:0] voc_data;
    logic                   scan_done;
    scan_t                  scan;
    logic                   match_done;
    match_t                 match;
    logic                   out_we;
    logic [`ENC_ADDR_W-1:0] out_waddr;
    out_byte_u              out_wdata;

    assign in_we  = load_en && (load_sel == SEL_INPUT);
    assign voc_we = load_en && (load_sel == SEL_VOCAB);

    word_sram input_mem (
        .clk     (clk),
        .we      (in_we),
        .waddr   (load_addr),
        .wdata   (load_data),
        .raddr_a (scan_addr),
        .rdata_a (scan_data),
        .raddr_b (match_in_addr),
        .rdata_b (match_in_data)
    );

    word_sram vocab_mem (
        .clk     (clk),
        .we      (voc_we),
        .waddr   (load_addr),
        .wdata   (load_data),
        .raddr_a (voc_addr),
        .rdata_a (voc_data),
        .raddr_b ('0),
        .rdata_b ()
    );

    word_sram output_mem (
        .clk     (clk),
        .we      (out_we),
        .waddr   (out_waddr),
        .wdata   (out_wdata),
        .raddr_a (out_addr),
        .rdata_a (out_data),
        .raddr_b (out_addr),
        .rdata_b ()
    );

    word_scanner u_scanner (
        .clk       (clk),
        .rst_n     (rst_n),
        .word_go   (word_go),
        .word_addr (word_addr),
        .rd_addr   (scan_addr),
        .rd_data   (scan_data),
        .scan_done (scan_done),
        .scan      (scan)
    );

    vocab_matcher u_matcher (
        .clk        (clk),
        .rst_n      (rst_n),
        .word_go    (word_go),
        .word_addr  (word_addr),
        .in_addr    (match_in_addr),
        .in_data    (match_in_data),
        .voc_addr   (voc_addr),
        .voc_data   (voc_data),
        .match_done (match_done),
        .match      (match)
    );

    encode_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .done       (done),
        .word_go    (word_go),
        .word_addr  (word_addr),
        .scan_done  (scan_done),
        .scan       (scan),
        .match_done (match_done),
        .match      (match),
        .out_we     (out_we),
        .out_waddr  (out_waddr),
        .out_wdata  (out_wdata)
    );

endmodule

/* hw/vocab_matcher.sv */
`timescale 1ns/1ns
`include "enc_macros.svh"

module vocab_matcher (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   word_go,
    input  logic [`ENC_ADDR_W-1:0] word_addr,
    output logic [`ENC_ADDR_W-1:0] in_addr,
    input  logic [`ENC_DATA_W-1:0] in_data,
    output logic [`ENC_ADDR_W-1:0] voc_addr,
    input  logic [`ENC_DATA_W-1:0] voc_data,
    output logic                   match_done,
    output enc_pkg::match_t        match
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_ISSUE,
        M_CMP,
        M_SKIP
    } state_e;

    state_e                   state;
    logic [`ENC_ADDR_W-1:0]   ip;
    logic [`ENC_ADDR_W-1:0]   vp;
    logic [`ENC_ADDR_W-1:0]   base;
    logic [`ENC_CODE_BIT-1:0] idx;
    logic                     first; // Comparing the first byte of an entry
    logic                     found;

    assign in_addr  = ip;
    assign voc_addr = vp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= M_IDLE;
            ip         <= '0;
            vp         <= '0;
            base       <= '0;
            idx        <= '0;
            first      <= 1'b0;
            found      <= 1'b0;
            match_done <= 1'b0;
        end else begin
            match_done <= 1'b0;
            if (word_go) begin
                base  <= word_addr;
                ip    <= word_addr;
                vp    <= '0;
                idx   <= '0;
                found <= 1'b0;
                state <= M_ISSUE;
            end else begin
                case (state)
                    M_ISSUE: begin
                        ip    <= ip + 1'b1;
                        vp    <= vp + 1'b1;
                        first <= 1'b1;
                        state <= M_CMP;
                    end
                    M_CMP: begin
                        if (first && voc_data == '0) begin
                            match_done <= 1'b1; // Empty entry ends the table
                            state      <= M_IDLE;
                        end else if (voc_data == in_data) begin
                            if (voc_data == '0) begin
                                found      <= 1'b1;
                                match_done <= 1'b1;
                                state      <= M_IDLE;
                            end else begin
                                ip    <= ip + 1'b1;
                                vp    <= vp + 1'b1;
                                first <= 1'b0;
                            end
                        end else if (voc_data == '0) begin
                            // vp already sits on the next entry
                            ip    <= base;
                            idx   <= idx + 1'b1;
                            state <= M_ISSUE;
                        end else begin
                            vp    <= vp + 1'b1;
                            state <= M_SKIP;
                        end
                    end
                    M_SKIP: begin
                        if (voc_data == '0) begin
                            ip    <= base;
                            idx   <= idx + 1'b1;
                            state <= M_ISSUE;
                        end else begin
                            vp <= vp + 1'b1;
                        end
                    end
                    default: state <= M_IDLE;
                endcase
            end
        end
    end

    assign match.found = found;
    assign match.index = idx;

    // Controller only starts a word after both results are in
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(match_done && word_go))
        else $error("vocab_matcher: new word started as the search finished");

endmodule

/* hw/word_scanner.sv */
`timescale 1ns/1ns
`include "enc_macros.svh"

module word_scanner (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   word_go,
    input  logic [`ENC_ADDR_W-1:0] word_addr,
    output logic [`ENC_ADDR_W-1:0] rd_addr,
    input  logic [`ENC_DATA_W-1:0] rd_data,
    output logic                   scan_done,
    output enc_pkg::scan_t         scan
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_CHECK
    } state_e;

    state_e                                    state;
    logic [`ENC_ADDR_W-1:0]                    ptr;
    logic [2:0]                                len;
    logic [`ENC_MAX_WORD-1:0][`ENC_DATA_W-1:0] chars;

    // In S_CHECK rd_data always holds the byte at ptr - 1
    assign rd_addr = ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            ptr       <= '0;
            len       <= '0;
            scan_done <= 1'b0;
        end else begin
            scan_done <= 1'b0;
            if (word_go) begin
                ptr   <= word_addr;
                len   <= '0;
                state <= S_ISSUE;
            end else begin
                case (state)
                    S_ISSUE: begin
                        ptr   <= ptr + 1'b1;
                        state <= S_CHECK;
                    end
                    S_CHECK: begin
                        if (rd_data == '0) begin
                            scan_done <= 1'b1; // ptr already points past the zero
                            state     <= S_IDLE;
                        end else begin
                            ptr <= ptr + 1'b1;
                            len <= len + 3'd1;
                        end
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_CHECK && rd_data != '0 && len < `ENC_MAX_WORD) begin
            chars[len] <= rd_data;
        end
    end

    assign scan.word.len   = len;
    assign scan.word.chars = chars;
    assign scan.empty      = (len == '0);
    assign scan.next_addr  = ptr;

    // Text in the input memory must not hold a word longer than the buffer
    a_word_fits: assert property (@(posedge clk) disable iff (!rst_n)
        (state == S_CHECK && rd_data != '0) |-> len < `ENC_MAX_WORD)
        else $error("word_scanner: word longer than %0d characters", `ENC_MAX_WORD);

endmodule

/* hw/word_sram.sv */
`timescale 1ns/1ns
`include "enc_macros.svh"

module word_sram #(
    parameter int depth = 1 << `ENC_ADDR_W
) (
    input  logic                   clk,
    input  logic                   we,
    input  logic [`ENC_ADDR_W-1:0] waddr,
    input  logic [`ENC_DATA_W-1:0] wdata,
    input  logic [`ENC_ADDR_W-1:0] raddr_a,
    output logic [`ENC_DATA_W-1:0] rdata_a,
    input  logic [`ENC_ADDR_W-1:0] raddr_b,
    output logic [`ENC_DATA_W-1:0] rdata_b
);

    logic [`ENC_DATA_W-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Both reads see the byte as it was before a same-cycle write
    always_ff @(posedge clk) begin
        rdata_a <= mem[raddr_a];
        rdata_b <= mem[raddr_b];
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module token_encoder_tb -Mdir obj_dir -o token_encoder_sim

./obj_dir/token_encoder_sim | tee sim.log || true

if grep -qx "sim passed" sim.log; then
    echo "Simulation OK"
else
    echo "Simulation FAILED"
    exit 1
fi

/* sim/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b1;
        #1 rst_n = 1'b0; // Falling edge for the async reset
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* sim/token_encoder_tb.sv */
`timescale 1ns/1ns
`include "enc_macros.svh"

module token_encoder_tb;

    import enc_pkg::*;

    localparam int wait_limit = 2000;

    logic                   clk;
    logic                   rst_n;
    logic                   load_en;
    mem_sel_e               load_sel;
    logic [`ENC_ADDR_W-1:0] load_addr;
    logic [`ENC_DATA_W-1:0] load_data;
    logic                   start;
    logic                   done;
    logic [`ENC_ADDR_W-1:0] out_addr;
    out_byte_u              out_data;

    logic                   started; // First start has been driven
    logic                   start_d;
    logic                   rd_valid;
    logic [`ENC_DATA_W-1:0] rd_exp;
    logic                   chk_en;
    logic [`ENC_DATA_W-1:0] chk_exp;
    logic [`ENC_ADDR_W-1:0] chk_addr;
    logic [31:0]            lcg_state;
    string                  vocab[$];
    string                  words[$];
    logic [`ENC_DATA_W-1:0] img[$];
    logic [`ENC_DATA_W-1:0] exp_q[$];

    tb_clock clock_gen (.clk(clk), .rst_n(rst_n));

    token_encoder uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_sel  (load_sel),
        .load_addr (load_addr),
        .load_data (load_data),
        .start     (start),
        .done      (done),
        .out_addr  (out_addr),
        .out_data  (out_data)
    );

    // Readback data lands one cycle after its address
    always @(posedge clk) begin
        start_d  <= start;
        chk_en   <= rd_valid;
        chk_exp  <= rd_exp;
        chk_addr <= out_addr;
    end

    task automatic stop_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic fail_run(input string why);
        $display("Error at %0t ns: %s", $time, why);
        stop_run();
    endtask

    task automatic report_mismatch(input string view, input logic [`ENC_ADDR_W-1:0] addr,
                                   input logic [`ENC_DATA_W-1:0] exp_b,
                                   input logic [`ENC_DATA_W-1:0] got_b);
        $display("[FAIL] %0t ns: %s view at output address %0d, expected %h, got %h",
                 $time, view, addr, exp_b, got_b);
        stop_run();
    endtask

    a_idle_done: assert property (@(posedge clk) !started |-> !done)
        else fail_run("done was high before the first start");

    a_done_drops: assert property (@(posedge clk) start_d |-> !done)
        else fail_run("done did not drop on the cycle after start");

    a_code_view: assert property (@(posedge clk)
        chk_en && chk_exp[`ENC_CODE_BIT] |-> out_data.code.is_code
            && out_data.code.index == chk_exp[`ENC_CODE_BIT-1:0])
        else report_mismatch("code", $sampled(chk_addr), $sampled(chk_exp),
                             $sampled(out_data.raw));

    a_raw_view: assert property (@(posedge clk)
        chk_en && !chk_exp[`ENC_CODE_BIT] |-> out_data.raw == chk_exp)
        else report_mismatch("raw", $sampled(chk_addr), $sampled(chk_exp),
                             $sampled(out_data.raw));

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int pick(input int n);
        return int'(lcg_next() >> 16) % n;
    endfunction

    // Each word or entry closed by a zero and one more zero at the end
    task automatic build_image(input bit use_vocab);
        string w;
        int    n;
        img.delete();
        n = use_vocab ? vocab.size() : words.size();
        for (int i = 0; i < n; i++) begin
            w = use_vocab ? vocab[i] : words[i];
            for (int j = 0; j < w.len(); j++) begin
                img.push_back(w[j]);
            end
            img.push_back('0);
        end
        img.push_back('0);
    endtask

    task automatic model_stream();
        string w;
        int    hit;
        exp_q.delete();
        foreach (words[i]) begin
            w   = words[i];
            hit = -1;
            foreach (vocab[k]) begin
                if (hit < 0 && vocab[k] == w) begin
                    hit = k;
                end
            end
            if (hit >= 0) begin
                exp_q.push_back(8'(hit) | (8'd1 << `ENC_CODE_BIT));
            end else begin
                for (int j = 0; j < w.len(); j++) begin
                    exp_q.push_back(w[j]);
                end
            end
            exp_q.push_back('0);
        end
        exp_q.push_back('0); // End of stream
    endtask

    task automatic load_mem(input mem_sel_e sel);
        foreach (img[i]) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_sel  <= sel;
            load_addr <= `ENC_ADDR_W'(i);
            load_data <= img[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic run_encode();
        int cycles;
        @(posedge clk);
        start   <= 1'b1;
        started <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        cycles = 0;
        while (!done) begin
            @(posedge clk);
            cycles++;
            if (cycles > wait_limit) begin
                fail_run("encoder did not raise done within the cycle limit");
            end
        end
    endtask

    task automatic check_stream();
        foreach (exp_q[i]) begin
            @(posedge clk);
            out_addr <= `ENC_ADDR_W'(i);
            rd_valid <= 1'b1;
            rd_exp   <= exp_q[i];
        end
        @(posedge clk);
        rd_valid <= 1'b0;
        repeat (2) @(posedge clk); // Last compare fires here
    endtask

    task automatic encode_words();
        build_image(1'b0);
        load_mem(SEL_INPUT);
        model_stream();
        run_encode();
        check_stream();
    endtask

    task automatic random_sentence();
        string w;
        int    len;
        words.delete();
        repeat (1 + pick(6)) begin
            w   = "";
            len = 1 + pick(`ENC_MAX_WORD);
            repeat (len) begin
                w = $sformatf("%s%c", w, 8'h61 + pick(4)); // Letters a to d
            end
            words.push_back(w);
        end
    endtask

    initial begin
        int cycles;
        load_en   = 1'b0;
        load_sel  = SEL_INPUT;
        load_addr = '0;
        load_data = '0;
        start     = 1'b0;
        out_addr  = '0;
        started   = 1'b0;
        start_d   = 1'b0;
        rd_valid  = 1'b0;
        rd_exp    = '0;
        chk_en    = 1'b0;
        chk_exp   = '0;
        chk_addr  = '0;
        lcg_state = 32'h36b6_8ce2;

        cycles = 0;
        @(posedge clk);
        while (!rst_n) begin
            @(posedge clk);
            cycles++;
            if (cycles > wait_limit) begin
                fail_run("reset was never released");
            end
        end
        repeat (4) @(posedge clk); // Idle with done low

        vocab = '{"ab", "c", "abcd", "dd", "bca", "da"};
        build_image(1'b1);
        load_mem(SEL_VOCAB);

        // Prefix cases plus first and last entries
        words = '{"ab", "a", "abc", "abcd", "da", "bb"};
        encode_words();

        repeat (4) begin
            random_sentence();
            encode_words();
        end

        words.delete();
        encode_words();

        vocab = '{"bb", "a"};
        build_image(1'b1);
        load_mem(SEL_VOCAB);
        words = '{"ab", "a", "abc", "abcd", "da", "bb"};
        encode_words();

        $display("sim passed");
        $finish;
    end

endmodule
